/* source/rv_pkg.sv */
// core widths, opcode, funct3 and ALU encodings, data RAM depth, decode and commit structs
package rv_pkg;

	localparam int XLEN = 64;
	localparam int REG_AW = 5;
	localparam logic [XLEN-1:0] RESET_PC = '0;
	localparam int DMEM_WORDS = 32; // 64-bit words

	typedef enum logic [6:0] {
		OP_IMM = 7'b0010011,
		OP     = 7'b0110011,
		LUI    = 7'b0110111,
		AUIPC  = 7'b0010111,
		BRANCH = 7'b1100011,
		JAL    = 7'b1101111,
		JALR   = 7'b1100111,
		LOAD   = 7'b0000011,
		STORE  = 7'b0100011
	} opcode_e;

	typedef enum logic [4:0] {
		ALU_ZERO, ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_XOR,
		ALU_OR, ALU_AND, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI,
		ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU
	} alu_op_e;

	// op and op-imm group
	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_SLL     = 3'b001;
	localparam logic [2:0] F3_SLT     = 3'b010;
	localparam logic [2:0] F3_SLTU    = 3'b011;
	localparam logic [2:0] F3_XOR     = 3'b100;
	localparam logic [2:0] F3_SR      = 3'b101; // srl/sra by bit 30
	localparam logic [2:0] F3_OR      = 3'b110;
	localparam logic [2:0] F3_AND     = 3'b111;

	localparam logic [2:0] F3_BEQ  = 3'b000;
	localparam logic [2:0] F3_BNE  = 3'b001;
	localparam logic [2:0] F3_BLT  = 3'b100;
	localparam logic [2:0] F3_BGE  = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110;
	localparam logic [2:0] F3_BGEU = 3'b111;

	localparam logic [2:0] F3_LB  = 3'b000;
	localparam logic [2:0] F3_LH  = 3'b001;
	localparam logic [2:0] F3_LW  = 3'b010;
	localparam logic [2:0] F3_LD  = 3'b011;
	localparam logic [2:0] F3_LBU = 3'b100;
	localparam logic [2:0] F3_LHU = 3'b101;
	localparam logic [2:0] F3_LWU = 3'b110;

	localparam logic [2:0] F3_SB = 3'b000;
	localparam logic [2:0] F3_SH = 3'b001;
	localparam logic [2:0] F3_SW = 3'b010;
	localparam logic [2:0] F3_SD = 3'b011;

	typedef struct packed {
		logic       r_ena;
		logic       w_ena;
		logic       to_reg;
		logic       ext_un;
		logic [7:0] byte_enable; // lane 0 based
	} mem_ctrl_t;

	typedef struct packed {
		alu_op_e           alu_op;
		logic [XLEN-1:0]   op1;
		logic [XLEN-1:0]   op2;
		logic              rd_w_ena;
		logic [REG_AW-1:0] rd_w_addr;
		logic              branch;
		logic [1:0]        jump; // [1] jal, [0] jalr
		logic [XLEN-1:0]   b_offset;
		logic [XLEN-1:0]   j_offset;
		mem_ctrl_t         mem;
	} dec_ctrl_t;

	typedef struct packed {
		logic [XLEN-1:0]   pc;
		logic [XLEN-1:0]   next_pc;
		logic              rd_w_ena;
		logic [REG_AW-1:0] rd_w_addr;
		logic [XLEN-1:0]   rd_data;
	} commit_t;

endpackage

/* source/id_stage.sv */
// id_stage: instruction decoder producing register reads and the control struct
`timescale 1ns/10ps

module id_stage (
	input  logic                      rst,
	input  logic [31:0]               inst,
	input  logic [rv_pkg::XLEN-1:0]   pc,
	input  logic [rv_pkg::XLEN-1:0]   rs1_data,
	input  logic [rv_pkg::XLEN-1:0]   rs2_data,
	output logic                      rs1_r_ena,
	output logic [rv_pkg::REG_AW-1:0] rs1_r_addr,
	output logic                      rs2_r_ena,
	output logic [rv_pkg::REG_AW-1:0] rs2_r_addr,
	output rv_pkg::dec_ctrl_t         ctrl
);

	rv_pkg::opcode_e opcode;
	logic [2:0] funct3;
	logic [rv_pkg::XLEN-1:0] imm_i;
	logic [rv_pkg::XLEN-1:0] imm_s;
	logic [rv_pkg::XLEN-1:0] imm_b;
	logic [rv_pkg::XLEN-1:0] imm_u;
	logic [rv_pkg::XLEN-1:0] imm_j;
	logic [rv_pkg::XLEN-1:0] shamt_imm;
	logic is_load;
	logic is_store;
	logic is_jal;
	logic is_jalr;
	logic [7:0] byte_en;

	assign opcode = rv_pkg::opcode_e'(inst[6:0]);
	assign funct3 = inst[14:12];

	assign imm_i = {{52{inst[31]}}, inst[31:20]};
	assign imm_s = {{52{inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_b = {{52{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};
	assign imm_j = {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
	assign shamt_imm = {{(rv_pkg::XLEN-6){1'b0}}, inst[25:20]}; // rv64 6-bit shamt

	assign is_load  = (opcode == rv_pkg::LOAD);
	assign is_store = (opcode == rv_pkg::STORE);
	assign is_jal   = (opcode == rv_pkg::JAL);
	assign is_jalr  = (opcode == rv_pkg::JALR);

	assign rs1_r_addr = rst ? '0 : inst[19:15];
	assign rs2_r_addr = rst ? '0 : inst[24:20];

	// access size, shifted by the address later in mem_stage
	always_comb begin
		byte_en = 8'h00;
		if (is_load) begin
			case (funct3)
				rv_pkg::F3_LB, rv_pkg::F3_LBU: byte_en = 8'h01;
				rv_pkg::F3_LH, rv_pkg::F3_LHU: byte_en = 8'h03;
				rv_pkg::F3_LW, rv_pkg::F3_LWU: byte_en = 8'h0f;
				rv_pkg::F3_LD:                 byte_en = 8'hff;
				default:                       byte_en = 8'h00;
			endcase
		end else if (is_store) begin
			case (funct3)
				rv_pkg::F3_SB: byte_en = 8'h01;
				rv_pkg::F3_SH: byte_en = 8'h03;
				rv_pkg::F3_SW: byte_en = 8'h0f;
				rv_pkg::F3_SD: byte_en = 8'hff;
				default:       byte_en = 8'h00;
			endcase
		end
	end

	always_comb begin
		ctrl = '0;
		rs1_r_ena = 1'b0;
		rs2_r_ena = 1'b0;
		if (!rst) begin
			ctrl.rd_w_addr = inst[11:7];
			ctrl.branch = (opcode == rv_pkg::BRANCH);
			ctrl.jump = {is_jal, is_jalr};
			ctrl.b_offset = imm_b;
			ctrl.j_offset = is_jalr ? imm_i : (is_jal ? imm_j : '0);
			ctrl.mem.r_ena = is_load;
			ctrl.mem.w_ena = is_store;
			ctrl.mem.to_reg = is_load;
			ctrl.mem.ext_un = is_load && (funct3 == rv_pkg::F3_LBU ||
				funct3 == rv_pkg::F3_LHU || funct3 == rv_pkg::F3_LWU);
			ctrl.mem.byte_enable = byte_en;
			case (opcode)
				rv_pkg::OP_IMM: begin
					rs1_r_ena = 1'b1;
					ctrl.rd_w_ena = 1'b1;
					ctrl.op1 = rs1_data;
					ctrl.op2 = imm_i;
					case (funct3)
						rv_pkg::F3_ADD_SUB: ctrl.alu_op = rv_pkg::ALU_ADD; // no subi
						rv_pkg::F3_SLT:     ctrl.alu_op = rv_pkg::ALU_SLT;
						rv_pkg::F3_SLTU:    ctrl.alu_op = rv_pkg::ALU_SLTU;
						rv_pkg::F3_XOR:     ctrl.alu_op = rv_pkg::ALU_XOR;
						rv_pkg::F3_OR:      ctrl.alu_op = rv_pkg::ALU_OR;
						rv_pkg::F3_AND:     ctrl.alu_op = rv_pkg::ALU_AND;
						rv_pkg::F3_SLL: begin
							ctrl.alu_op = rv_pkg::ALU_SLL;
							ctrl.op2 = shamt_imm;
						end
						default: begin
							ctrl.alu_op = inst[30] ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
							ctrl.op2 = shamt_imm;
						end
					endcase
				end
				rv_pkg::OP: begin
					rs1_r_ena = 1'b1;
					rs2_r_ena = 1'b1;
					ctrl.rd_w_ena = 1'b1;
					ctrl.op1 = rs1_data;
					ctrl.op2 = rs2_data;
					case (funct3)
						rv_pkg::F3_ADD_SUB:
							ctrl.alu_op = inst[30] ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
						rv_pkg::F3_SLL:  ctrl.alu_op = rv_pkg::ALU_SLL;
						rv_pkg::F3_SLT:  ctrl.alu_op = rv_pkg::ALU_SLT;
						rv_pkg::F3_SLTU: ctrl.alu_op = rv_pkg::ALU_SLTU;
						rv_pkg::F3_XOR:  ctrl.alu_op = rv_pkg::ALU_XOR;
						rv_pkg::F3_OR:   ctrl.alu_op = rv_pkg::ALU_OR;
						rv_pkg::F3_AND:  ctrl.alu_op = rv_pkg::ALU_AND;
						default:
							ctrl.alu_op = inst[30] ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
					endcase
				end
				rv_pkg::LUI: begin
					ctrl.rd_w_ena = 1'b1;
					ctrl.op2 = imm_u;
					ctrl.alu_op = rv_pkg::ALU_LUI;
				end
				rv_pkg::AUIPC: begin
					ctrl.rd_w_ena = 1'b1;
					ctrl.op1 = pc;
					ctrl.op2 = imm_u;
					ctrl.alu_op = rv_pkg::ALU_ADD;
				end
				rv_pkg::BRANCH: begin
					rs1_r_ena = 1'b1;
					rs2_r_ena = 1'b1;
					ctrl.op1 = rs1_data;
					ctrl.op2 = rs2_data;
					case (funct3)
						rv_pkg::F3_BEQ:  ctrl.alu_op = rv_pkg::ALU_BEQ;
						rv_pkg::F3_BNE:  ctrl.alu_op = rv_pkg::ALU_BNE;
						rv_pkg::F3_BLT:  ctrl.alu_op = rv_pkg::ALU_BLT;
						rv_pkg::F3_BGE:  ctrl.alu_op = rv_pkg::ALU_BGE;
						rv_pkg::F3_BLTU: ctrl.alu_op = rv_pkg::ALU_BLTU;
						rv_pkg::F3_BGEU: ctrl.alu_op = rv_pkg::ALU_BGEU;
						default:         ctrl.alu_op = rv_pkg::ALU_ZERO; // never taken
					endcase
				end
				rv_pkg::JAL, rv_pkg::JALR: begin
					rs1_r_ena = is_jalr; // jalr target base
					ctrl.rd_w_ena = 1'b1;
					ctrl.op1 = pc; // link value pc + 4
					ctrl.op2 = rv_pkg::XLEN'(4);
					ctrl.alu_op = rv_pkg::ALU_ADD;
				end
				rv_pkg::LOAD: begin
					rs1_r_ena = 1'b1;
					ctrl.rd_w_ena = 1'b1;
					ctrl.op1 = rs1_data;
					ctrl.op2 = imm_i;
					ctrl.alu_op = rv_pkg::ALU_ADD;
				end
				rv_pkg::STORE: begin
					rs1_r_ena = 1'b1;
					rs2_r_ena = 1'b1; // store data
					ctrl.op1 = rs1_data;
					ctrl.op2 = imm_s;
					ctrl.alu_op = rv_pkg::ALU_ADD;
				end
				default: ctrl = '0;
			endcase
		end
	end

endmodule

/* source/regfile.sv */
// regfile: 32 x 64 integer registers, two async read ports, one sync write port
`timescale 1ns/10ps

module regfile (
	input  logic                      clk,
	input  logic                      rs1_r_ena,
	input  logic [rv_pkg::REG_AW-1:0] rs1_r_addr,
	input  logic                      rs2_r_ena,
	input  logic [rv_pkg::REG_AW-1:0] rs2_r_addr,
	input  logic                      w_ena,
	input  logic [rv_pkg::REG_AW-1:0] w_addr,
	input  logic [rv_pkg::XLEN-1:0]   w_data,
	output logic [rv_pkg::XLEN-1:0]   rs1_data,
	output logic [rv_pkg::XLEN-1:0]   rs2_data
);

	logic [rv_pkg::XLEN-1:0] regs [2**rv_pkg::REG_AW];

	always_ff @(posedge clk) begin
		if (w_ena && w_addr != '0)
			regs[w_addr] <= w_data;
	end

	// x0 and disabled ports read zero
	always_comb begin
		if (rs1_r_ena && rs1_r_addr != '0)
			rs1_data = regs[rs1_r_addr];
		else
			rs1_data = '0;
	end

	always_comb begin
		if (rs2_r_ena && rs2_r_addr != '0)
			rs2_data = regs[rs2_r_addr];
		else
			rs2_data = '0;
	end

endmodule

/* source/exe_stage.sv */
// exe_stage: ALU, branch comparator and next-pc select
`timescale 1ns/10ps

module exe_stage (
	input  logic [rv_pkg::XLEN-1:0] pc,
	input  logic [rv_pkg::XLEN-1:0] rs1_data,
	input  rv_pkg::dec_ctrl_t       ctrl,
	output logic [rv_pkg::XLEN-1:0] alu_result,
	output logic [rv_pkg::XLEN-1:0] next_pc
);

	logic [rv_pkg::XLEN-1:0] op1;
	logic [rv_pkg::XLEN-1:0] op2;
	logic [5:0] shamt;
	logic eq;
	logic lt_s;
	logic lt_u;
	logic taken;
	logic [rv_pkg::XLEN-1:0] jalr_sum;

	assign op1 = ctrl.op1;
	assign op2 = ctrl.op2;
	assign shamt = op2[5:0];

	assign eq   = (op1 == op2);
	assign lt_s = ($signed(op1) < $signed(op2));
	assign lt_u = (op1 < op2);

	always_comb begin
		alu_result = '0;
		taken = 1'b0;
		case (ctrl.alu_op)
			rv_pkg::ALU_ADD:  alu_result = op1 + op2;
			rv_pkg::ALU_SUB:  alu_result = op1 - op2;
			rv_pkg::ALU_SLT:  alu_result = {{(rv_pkg::XLEN-1){1'b0}}, lt_s};
			rv_pkg::ALU_SLTU: alu_result = {{(rv_pkg::XLEN-1){1'b0}}, lt_u};
			rv_pkg::ALU_XOR:  alu_result = op1 ^ op2;
			rv_pkg::ALU_OR:   alu_result = op1 | op2;
			rv_pkg::ALU_AND:  alu_result = op1 & op2;
			rv_pkg::ALU_SLL:  alu_result = op1 << shamt;
			rv_pkg::ALU_SRL:  alu_result = op1 >> shamt;
			rv_pkg::ALU_SRA:  alu_result = $signed(op1) >>> shamt;
			rv_pkg::ALU_LUI:  alu_result = op2; // imm already placed
			rv_pkg::ALU_BEQ:  taken = eq;
			rv_pkg::ALU_BNE:  taken = !eq;
			rv_pkg::ALU_BLT:  taken = lt_s;
			rv_pkg::ALU_BGE:  taken = !lt_s;
			rv_pkg::ALU_BLTU: taken = lt_u;
			rv_pkg::ALU_BGEU: taken = !lt_u;
			default:          alu_result = '0;
		endcase
	end

	assign jalr_sum = rs1_data + ctrl.j_offset;

	// taken branch, then jal, then jalr, else sequential
	always_comb begin
		if (ctrl.branch && taken)
			next_pc = pc + ctrl.b_offset;
		else if (ctrl.jump[1])
			next_pc = pc + ctrl.j_offset;
		else if (ctrl.jump[0])
			next_pc = {jalr_sum[rv_pkg::XLEN-1:1], 1'b0};
		else
			next_pc = pc + rv_pkg::XLEN'(4);
	end

endmodule

/* source/mem_stage.sv */
// mem_stage: data RAM with lane-aligned stores and extended loads
`timescale 1ns/10ps

module mem_stage (
	input  logic                    clk,
	input  logic                    we,
	input  rv_pkg::mem_ctrl_t       mem_ctrl,
	input  logic [rv_pkg::XLEN-1:0] addr,
	input  logic [rv_pkg::XLEN-1:0] store_data,
	output logic [rv_pkg::XLEN-1:0] load_data
);

	logic [rv_pkg::XLEN-1:0] ram [rv_pkg::DMEM_WORDS];
	logic [$clog2(rv_pkg::DMEM_WORDS)-1:0] word_idx;
	logic [2:0] lane;
	logic [7:0] lane_en;
	logic [rv_pkg::XLEN-1:0] wdata_sh;
	logic [rv_pkg::XLEN-1:0] rdata_sh;
	logic [rv_pkg::XLEN-1:0] size_mask;
	logic sign;

	// upper address bits wrap
	assign word_idx = addr[3 +: $clog2(rv_pkg::DMEM_WORDS)];
	assign lane = addr[2:0];

	assign lane_en = mem_ctrl.byte_enable << lane;
	assign wdata_sh = store_data << {lane, 3'b000};

	always_ff @(posedge clk) begin
		if (we && mem_ctrl.w_ena) begin
			for (int i = 0; i < 8; i++) begin
				if (lane_en[i])
					ram[word_idx][8*i +: 8] <= wdata_sh[8*i +: 8];
			end
		end
	end

	assign rdata_sh = ram[word_idx] >> {lane, 3'b000};

	always_comb begin
		for (int i = 0; i < 8; i++)
			size_mask[8*i +: 8] = {8{mem_ctrl.byte_enable[i]}};
	end

	// msb of the access size, none for ld
	always_comb begin
		case (mem_ctrl.byte_enable)
			8'h01:   sign = rdata_sh[7];
			8'h03:   sign = rdata_sh[15];
			8'h0f:   sign = rdata_sh[31];
			default: sign = 1'b0;
		endcase
	end

	always_comb begin
		if (mem_ctrl.r_ena)
			load_data = (rdata_sh & size_mask) |
				(~size_mask & {rv_pkg::XLEN{sign & ~mem_ctrl.ext_un}});
		else
			load_data = '0;
	end

endmodule

/* source/core_top.sv */
// core_top: pc register, decode/execute/memory instances, write-back and commit port
`timescale 1ns/10ps

module core_top (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    inst_valid,
	input  logic [31:0]             inst,
	output logic [rv_pkg::XLEN-1:0] pc,
	output logic                    commit_valid,
	output rv_pkg::commit_t         commit
);

	logic rs1_r_ena;
	logic rs2_r_ena;
	logic [rv_pkg::REG_AW-1:0] rs1_r_addr;
	logic [rv_pkg::REG_AW-1:0] rs2_r_addr;
	logic [rv_pkg::XLEN-1:0] rs1_data;
	logic [rv_pkg::XLEN-1:0] rs2_data;
	rv_pkg::dec_ctrl_t ctrl;
	logic [rv_pkg::XLEN-1:0] alu_result;
	logic [rv_pkg::XLEN-1:0] next_pc;
	logic [rv_pkg::XLEN-1:0] load_data;
	logic [rv_pkg::XLEN-1:0] wb_data;
	logic rd_write;
	rv_pkg::commit_t commit_d;

	id_stage u_id (
		.rst(rst), .inst(inst), .pc(pc),
		.rs1_data(rs1_data), .rs2_data(rs2_data),
		.rs1_r_ena(rs1_r_ena), .rs1_r_addr(rs1_r_addr),
		.rs2_r_ena(rs2_r_ena), .rs2_r_addr(rs2_r_addr),
		.ctrl(ctrl)
	);

	assign wb_data = ctrl.mem.to_reg ? load_data : alu_result;
	assign rd_write = ctrl.rd_w_ena && ctrl.rd_w_addr != '0; // x0 writes dropped

	regfile u_rf (
		.clk(clk),
		.rs1_r_ena(rs1_r_ena), .rs1_r_addr(rs1_r_addr),
		.rs2_r_ena(rs2_r_ena), .rs2_r_addr(rs2_r_addr),
		.w_ena(inst_valid && rd_write), .w_addr(ctrl.rd_w_addr), .w_data(wb_data),
		.rs1_data(rs1_data), .rs2_data(rs2_data)
	);

	exe_stage u_exe (
		.pc(pc), .rs1_data(rs1_data), .ctrl(ctrl),
		.alu_result(alu_result), .next_pc(next_pc)
	);

	mem_stage u_mem (
		.clk(clk), .we(inst_valid), .mem_ctrl(ctrl.mem),
		.addr(alu_result), .store_data(rs2_data), .load_data(load_data)
	);

	// rd fields read zero when nothing is written
	always_comb begin
		commit_d.pc = pc;
		commit_d.next_pc = next_pc;
		commit_d.rd_w_ena = rd_write;
		commit_d.rd_w_addr = rd_write ? ctrl.rd_w_addr : '0;
		commit_d.rd_data = rd_write ? wb_data : '0;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= rv_pkg::RESET_PC;
			commit_valid <= 1'b0;
			commit <= '0;
		end else begin
			commit_valid <= inst_valid;
			if (inst_valid) begin
				pc <= next_pc;
				commit <= commit_d;
			end
		end
	end

endmodule

/* tests/core_tb.sv */
// core_tb: clock, reset, instruction table with expected commits, idle gaps, checks, watchdog
`timescale 1ns/10ps

module core_tb;

	logic clk;
	logic rst;
	logic inst_valid;
	logic [31:0] inst;
	logic [rv_pkg::XLEN-1:0] pc;
	logic commit_valid;
	rv_pkg::commit_t commit;

	logic [31:0] prog_inst [$];
	rv_pkg::commit_t prog_exp [$];
	logic [rv_pkg::XLEN-1:0] tpc; // pc while the table is built
	logic [31:0] lfsr;
	logic pend_valid;
	rv_pkg::commit_t pend_exp;
	bit table_ready;
	int commit_errs;
	int valid_errs;
	int pc_errs;

	core_top uut (
		.clk(clk), .rst(rst), .inst_valid(inst_valid), .inst(inst),
		.pc(pc), .commit_valid(commit_valid), .commit(commit)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
		return {f7, rs2, rs1, f3, rd, rv_pkg::OP};
	endfunction

	function automatic logic [31:0] i_type(input logic [6:0] opc, input logic [2:0] f3,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] s_type(input logic [2:0] f3, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [11:0] imm);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], rv_pkg::STORE};
	endfunction

	function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [4:0] rs1,
		input logic [4:0] rs2, input logic [12:0] imm);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_pkg::BRANCH};
	endfunction

	function automatic logic [31:0] u_type(input logic [6:0] opc, input logic [4:0] rd,
		input logic [19:0] imm);
		return {imm, rd, opc};
	endfunction

	function automatic logic [31:0] j_type(input logic [4:0] rd, input logic [20:0] imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_pkg::JAL};
	endfunction

	// fibonacci, taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// x0 as rd means no register write in the commit
	task automatic add_flow(input logic [31:0] word, input logic [4:0] rd,
		input logic [rv_pkg::XLEN-1:0] data, input logic [rv_pkg::XLEN-1:0] npc);
		rv_pkg::commit_t e;
		e.pc = tpc;
		e.next_pc = npc;
		e.rd_w_ena = (rd != 0);
		e.rd_w_addr = rd;
		e.rd_data = (rd != 0) ? data : '0;
		prog_inst.push_back(word);
		prog_exp.push_back(e);
		tpc = npc;
	endtask

	task automatic add_seq(input logic [31:0] word, input logic [4:0] rd,
		input logic [rv_pkg::XLEN-1:0] data);
		add_flow(word, rd, data, tpc + 4);
	endtask

	task automatic build_program();
		logic [rv_pkg::XLEN-1:0] link_a;
		logic [rv_pkg::XLEN-1:0] link_b;
		tpc = rv_pkg::RESET_PC;
		add_seq(i_type(rv_pkg::OP_IMM, rv_pkg::F3_ADD_SUB, 1, 0, -12'sd1), 1, '1);
		add_seq(i_type(rv_pkg::OP_IMM, rv_pkg::F3_ADD_SUB, 2, 0, 12'd5), 2, 64'd5);
		add_seq(u_type(rv_pkg::LUI, 11, 20'h80000), 11, 64'hFFFF_FFFF_8000_0000);
		add_seq(i_type(rv_pkg::OP_IMM, rv_pkg::F3_SLT, 3, 1, 12'd0), 3, 64'd1);
		add_seq(i_type(rv_pkg::OP_IMM, rv_pkg::F3_SLTU, 4, 2, 12'd3), 4, 64'd0);
		add_seq(i_type(rv_pkg::OP_IMM, rv_pkg::F3_XOR, 5, 2, 12'h0f0), 5, 64'hf5);
		add_seq(i_type(rv_pkg::OP_IMM, rv_pkg::F3_OR, 6, 2, 12'hff0), 6, 64'hFFFF_FFFF_FFFF_FFF5);
		add_seq(i_type(rv_pkg::OP_IMM, rv_pkg::F3_AND, 7, 6, 12'h0ff), 7, 64'hf5);
		add_seq(i_type(rv_pkg::OP_IMM, rv_pkg::F3_SLL, 8, 2, 12'd40), 8, 64'h0000_0500_0000_0000);
		add_seq(i_type(rv_pkg::OP_IMM, rv_pkg::F3_SR, 9, 11, 12'd36), 9, 64'h0FFF_FFFF);
		add_seq(i_type(rv_pkg::OP_IMM, rv_pkg::F3_SR, 10, 11, 12'h404), 10, 64'hFFFF_FFFF_F800_0000);
		// register-register, sources from above
		add_seq(r_type(7'h00, rv_pkg::F3_ADD_SUB, 12, 2, 8), 12, 64'h0000_0500_0000_0005);
		add_seq(r_type(7'h20, rv_pkg::F3_ADD_SUB, 13, 2, 1), 13, 64'd6);
		add_seq(r_type(7'h00, rv_pkg::F3_SLT, 14, 11, 2), 14, 64'd1);
		add_seq(r_type(7'h00, rv_pkg::F3_SLTU, 15, 2, 11), 15, 64'd1);
		add_seq(r_type(7'h00, rv_pkg::F3_XOR, 16, 6, 1), 16, 64'ha);
		add_seq(r_type(7'h00, rv_pkg::F3_OR, 17, 10, 2), 17, 64'hFFFF_FFFF_F800_0005);
		add_seq(r_type(7'h00, rv_pkg::F3_AND, 18, 10, 9), 18, 64'h0800_0000);
		add_seq(r_type(7'h00, rv_pkg::F3_SLL, 19, 2, 9), 19, 64'h8000_0000_0000_0000); // by 63
		add_seq(r_type(7'h00, rv_pkg::F3_SR, 20, 11, 2), 20, 64'h07FF_FFFF_FC00_0000);
		add_seq(r_type(7'h20, rv_pkg::F3_SR, 21, 11, 2), 21, 64'hFFFF_FFFF_FC00_0000);
		add_seq(u_type(rv_pkg::AUIPC, 22, 20'h12345), 22, tpc + 64'h1234_5000);
		add_seq(i_type(rv_pkg::OP_IMM, rv_pkg::F3_ADD_SUB, 0, 2, 12'd7), 0, 64'd0);
		add_seq(r_type(7'h00, rv_pkg::F3_ADD_SUB, 23, 0, 2), 23, 64'd5); // x0 still zero
		// stores into two words at address 64, then loads back
		add_seq(i_type(rv_pkg::OP_IMM, rv_pkg::F3_ADD_SUB, 24, 0, 12'd64), 24, 64'd64);
		add_seq(s_type(rv_pkg::F3_SD, 1, 24, 12'd0), 0, 64'd0);
		add_seq(s_type(rv_pkg::F3_SB, 13, 24, 12'd3), 0, 64'd0);
		add_seq(s_type(rv_pkg::F3_SH, 2, 24, 12'd4), 0, 64'd0);
		add_seq(s_type(rv_pkg::F3_SD, 1, 24, 12'd8), 0, 64'd0);
		add_seq(s_type(rv_pkg::F3_SW, 11, 24, 12'd12), 0, 64'd0);
		add_seq(i_type(rv_pkg::LOAD, rv_pkg::F3_LD, 26, 24, 12'd0), 26, 64'hFFFF_0005_06FF_FFFF);
		add_seq(i_type(rv_pkg::LOAD, rv_pkg::F3_LD, 27, 24, 12'd8), 27, 64'h8000_0000_FFFF_FFFF);
		add_seq(i_type(rv_pkg::LOAD, rv_pkg::F3_LB, 28, 24, 12'd2), 28, '1);
		add_seq(i_type(rv_pkg::LOAD, rv_pkg::F3_LBU, 29, 24, 12'd2), 29, 64'hff);
		add_seq(i_type(rv_pkg::LOAD, rv_pkg::F3_LH, 30, 24, 12'd14), 30, 64'hFFFF_FFFF_FFFF_8000);
		add_seq(i_type(rv_pkg::LOAD, rv_pkg::F3_LHU, 31, 24, 12'd14), 31, 64'h8000);
		add_seq(i_type(rv_pkg::LOAD, rv_pkg::F3_LW, 28, 24, 12'd12), 28, 64'hFFFF_FFFF_8000_0000);
		add_seq(i_type(rv_pkg::LOAD, rv_pkg::F3_LWU, 29, 24, 12'd12), 29, 64'h8000_0000);
		add_seq(i_type(rv_pkg::LOAD, rv_pkg::F3_LW, 30, 24, 12'd4), 30, 64'hFFFF_FFFF_FFFF_0005);
		// x1 = -1, x2 = 5
		add_flow(b_type(rv_pkg::F3_BEQ, 2, 2, 13'd8), 0, 64'd0, tpc + 8);
		add_flow(b_type(rv_pkg::F3_BNE, 2, 2, 13'd8), 0, 64'd0, tpc + 4);
		add_flow(b_type(rv_pkg::F3_BLT, 1, 2, -13'sd12), 0, 64'd0, tpc - 12);
		add_flow(b_type(rv_pkg::F3_BLT, 2, 1, 13'd8), 0, 64'd0, tpc + 4);
		add_flow(b_type(rv_pkg::F3_BGE, 1, 2, 13'd16), 0, 64'd0, tpc + 4);
		add_flow(b_type(rv_pkg::F3_BLTU, 1, 2, 13'd16), 0, 64'd0, tpc + 4);
		add_flow(b_type(rv_pkg::F3_BGEU, 1, 2, -13'sd8), 0, 64'd0, tpc - 8);
		add_flow(b_type(rv_pkg::F3_BGEU, 2, 1, 13'd8), 0, 64'd0, tpc + 4);
		add_flow(b_type(rv_pkg::F3_BNE, 1, 2, 13'd20), 0, 64'd0, tpc + 20);
		add_flow(b_type(rv_pkg::F3_BGE, 2, 1, 13'd12), 0, 64'd0, tpc + 12);
		add_flow(b_type(rv_pkg::F3_BLTU, 2, 1, -13'sd16), 0, 64'd0, tpc - 16);
		add_flow(b_type(rv_pkg::F3_BEQ, 1, 2, -13'sd4), 0, 64'd0, tpc + 4);
		// jumps with link values read back
		link_a = tpc + 4;
		add_flow(j_type(5, 21'd32), 5, link_a, tpc + 32);
		link_b = tpc + 4;
		add_flow(i_type(rv_pkg::JALR, 3'b000, 7, 24, 12'd5), 7, link_b, 64'd68); // 69, bit 0 off
		add_flow(j_type(0, -21'sd16), 0, 64'd0, tpc - 16);
		add_seq(r_type(7'h20, rv_pkg::F3_ADD_SUB, 25, 7, 5), 25, link_b - link_a);
		add_flow(i_type(rv_pkg::JALR, 3'b000, 8, 24, -12'sd3), 8, tpc + 4, 64'd60);
	endtask

	task automatic check_commit(input rv_pkg::commit_t exp);
		if (commit !== exp) begin
			commit_errs++;
			$display("** Error at %0t: commit record mismatch", $time);
			$display("   got      pc %h next %h w %b rd %0d data %h", commit.pc,
				commit.next_pc, commit.rd_w_ena, commit.rd_w_addr, commit.rd_data);
			$display("   expected pc %h next %h w %b rd %0d data %h", exp.pc,
				exp.next_pc, exp.rd_w_ena, exp.rd_w_addr, exp.rd_data);
		end
	endtask

	task automatic check_valid(input logic exp);
		if (commit_valid !== exp) begin
			valid_errs++;
			$display("** Error at %0t: commit_valid is %b, expected %b", $time, commit_valid, exp);
		end
	endtask

	task automatic check_pc(input logic [rv_pkg::XLEN-1:0] exp);
		if (pc !== exp) begin
			pc_errs++;
			$display("** Error at %0t: pc is %h, expected %h", $time, pc, exp);
		end
	endtask

	// result of the previous cycle's inputs is checked at the negedge
	task automatic drive_cycle(input logic v, input logic [31:0] word,
		input rv_pkg::commit_t e);
		@(posedge clk);
		inst_valid <= v;
		inst <= word;
		@(negedge clk);
		check_valid(pend_valid);
		if (pend_valid)
			check_commit(pend_exp);
		if (v)
			check_pc(e.pc); // earlier instructions already retired
		pend_valid = v;
		pend_exp = e;
	endtask

	initial begin
		logic [1:0] gap;
		rst = 1'b1;
		inst_valid = 1'b0;
		inst = '0;
		lfsr = 32'ha37d_32b6;
		pend_valid = 1'b0;
		pend_exp = '0;
		commit_errs = 0;
		valid_errs = 0;
		pc_errs = 0;
		build_program();
		table_ready = 1'b1;
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check_valid(1'b0);
		check_pc(rv_pkg::RESET_PC);
		check_commit('0);
		for (int i = 0; i < prog_inst.size(); i++) begin
			lfsr = lfsr_step(lfsr);
			gap[1] = lfsr[0];
			lfsr = lfsr_step(lfsr);
			gap[0] = lfsr[0];
			repeat (gap) drive_cycle(1'b0, '0, '0);
			drive_cycle(1'b1, prog_inst[i], prog_exp[i]);
		end
		drive_cycle(1'b0, '0, '0);
		drive_cycle(1'b0, '0, '0);
		$display("errors: commit %0d, valid %0d, pc %0d", commit_errs, valid_errs, pc_errs);
		if (commit_errs + valid_errs + pc_errs == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

	// at most four cycles per entry plus reset and flush
	initial begin
		int limit;
		wait (table_ready);
		limit = prog_inst.size() * 5 + 50;
		repeat (limit) @(posedge clk);
		$display("timeout: the run did not finish within %0d cycles", limit);
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

/* sources.f */
source/rv_pkg.sv
source/id_stage.sv
source/regfile.sv
source/exe_stage.sv
source/mem_stage.sv
source/core_top.sv
tests/core_tb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     := --binary --timing -j 0
TOP       := core_tb
FILELIST  := sources.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := ALL TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)" && exit 1)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
